// ==== rtl/adc_capture_macros.svh ====
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

// FIFO geometry, depth must stay a power of two
`define SAMPLE_FIFO_DEPTH 64
`define FIFO_PTR_BITS 6

// Samples per capture after reset
`define CAPTURE_LEN_RESET 16'd24

// Register map of the capture block
`define REG_FIFO_STAT          8'h10   // Error bits and empty flag
`define REG_FIFO_STATE         8'h11
`define REG_FIFO_FIRST_ERROR   8'h12   // FIFO state at first error
`define REG_CAPTURE_LEN        8'h13   // Two bytes, LSB first
`define REG_ADC_LOW_RES        8'h14
`define REG_UNDERFLOW_COUNT    8'h15
`define REG_NO_UNDERFLOW_ERROR 8'h16
`define REG_CAPTURE_CTRL       8'h17   // Bit 0 arms a capture
`define REG_FAST_FIFO_READ     8'h18
`define REG_ADC_READ           8'h19   // Streaming FIFO drain
`define REG_FIFO_COUNT         8'h1a

`endif

// ==== rtl/adc_capture_pkg.sv ====
package adc_capture_pkg;

  typedef logic [9:0] adc_sample_t;     // Raw ADC word
  typedef logic [7:0] reg_addr_t;
  typedef logic [6:0] reg_bytecnt_t;
  typedef logic [6:0] fifo_count_t;     // Holds 0 up to the full depth
  typedef logic [15:0] capture_len_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_RUN,
    CAP_DONE
  } capture_state_t;

  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PARTIAL,
    FIFO_FULL
  } fifo_state_t;

  // Sticky FIFO error flags
  typedef struct packed {
    logic overflow;
    logic underflow;
  } fifo_error_t;

  // One byte on its way into the FIFO
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } pack_push_t;

  typedef struct packed {
    logic enable;         // High only while capturing
    logic low_res;        // One byte per sample
    logic low_res_lsb;    // Keep the bottom 8 bits instead of the top 8
  } capture_cfg_t;

endpackage

// ==== rtl/adcfifo_regs.sv ====
`timescale 1ns/100ps
`include "adc_capture_macros.svh"

module adcfifo_regs import adc_capture_pkg::*; (
  input  logic           clk_usb,
  input  logic           reset,
  input  reg_addr_t      reg_address,
  input  reg_bytecnt_t   reg_bytecnt,
  input  logic [7:0]     reg_datai,
  input  logic           reg_read,
  input  logic           reg_write,
  output logic [7:0]     reg_datao,
  input  logic [7:0]     head_byte,
  input  fifo_count_t    fifo_count,
  input  fifo_state_t    fifo_state,
  input  fifo_error_t    errors,
  input  logic           sample_taken,
  input  logic           drop,
  output capture_cfg_t   cfg,
  output logic           fifo_rd_en,
  output logic           clear_fifo_errors,
  output logic           capture_done
);

  capture_state_t cap_state;
  capture_len_t   capture_len;
  capture_len_t   sample_cnt;
  logic           low_res;
  logic           low_res_lsb;
  logic           no_underflow_errors;
  logic           fast_read;
  logic           reg_read_r;
  logic           rd_rise;
  logic           fifo_rd_en_reg;
  logic [7:0]     underflow_count;
  fifo_state_t    first_error_state;
  logic           first_error_seen;
  logic [7:0]     fifo_stat;

  assign cfg = '{enable: (cap_state == CAP_RUN), low_res: low_res, low_res_lsb: low_res_lsb};
  assign capture_done = (cap_state == CAP_DONE);

  // Underflow flag can be masked while the counter keeps running
  assign fifo_stat = {5'b0, fifo_state == FIFO_EMPTY,
                      errors.underflow & ~no_underflow_errors, errors.overflow};

  // First cycle of a read of the streaming address
  assign rd_rise = reg_read & ~reg_read_r & (reg_address == `REG_ADC_READ);

  // Fast mode pops on the rising edge of the read itself
  assign fifo_rd_en = fast_read ? rd_rise : fifo_rd_en_reg;

  always_comb begin
    reg_datao = 8'h00;
    if (reg_read) begin
      case (reg_address)
        `REG_FIFO_STAT:          reg_datao = fifo_stat;
        `REG_FIFO_STATE:         reg_datao = {6'b0, fifo_state};
        `REG_FIFO_FIRST_ERROR:   reg_datao = {6'b0, first_error_state};
        `REG_CAPTURE_LEN: begin
          if (reg_bytecnt == 7'd0)
            reg_datao = capture_len[7:0];
          else if (reg_bytecnt == 7'd1)
            reg_datao = capture_len[15:8];
        end
        `REG_ADC_LOW_RES:        reg_datao = {6'b0, low_res_lsb, low_res};
        `REG_UNDERFLOW_COUNT:    reg_datao = underflow_count;
        `REG_NO_UNDERFLOW_ERROR: reg_datao = {7'b0, no_underflow_errors};
        `REG_CAPTURE_CTRL:       reg_datao = {6'b0, cap_state};
        `REG_FAST_FIFO_READ:     reg_datao = {7'b0, fast_read};
        `REG_ADC_READ:           reg_datao = head_byte;
        `REG_FIFO_COUNT:         reg_datao = {1'b0, fifo_count};
        default:                 reg_datao = 8'h00;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      capture_len <= `CAPTURE_LEN_RESET;
      low_res <= 1'b0;
      low_res_lsb <= 1'b0;
      no_underflow_errors <= 1'b0;
      clear_fifo_errors <= 1'b0;
    end else begin
      clear_fifo_errors <= 1'b0;   // Single cycle pulse
      if (reg_write) begin
        case (reg_address)
          `REG_FIFO_STAT:          clear_fifo_errors <= reg_datai[0];
          `REG_CAPTURE_LEN: begin
            if (reg_bytecnt == 7'd0)
              capture_len[7:0] <= reg_datai;
            else if (reg_bytecnt == 7'd1)
              capture_len[15:8] <= reg_datai;
          end
          `REG_ADC_LOW_RES:        {low_res_lsb, low_res} <= reg_datai[1:0];
          `REG_NO_UNDERFLOW_ERROR: no_underflow_errors <= reg_datai[0];
          default: ;
        endcase
      end
    end
  end

  // Fast mode only survives until the next write elsewhere
  always_ff @(posedge clk_usb) begin
    if (reset)
      fast_read <= 1'b0;
    else if (reg_write)
      fast_read <= (reg_address == `REG_FAST_FIFO_READ) & reg_datai[0];
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      cap_state <= CAP_IDLE;
      sample_cnt <= '0;
    end else if (reg_write && reg_address == `REG_CAPTURE_CTRL && reg_datai[0] &&
                 cap_state != CAP_RUN) begin
      cap_state <= CAP_RUN;   // Arm
      sample_cnt <= '0;
    end else if (cap_state == CAP_RUN && sample_taken) begin
      sample_cnt <= sample_cnt + 16'd1;
      if (sample_cnt + 16'd1 == capture_len)
        cap_state <= CAP_DONE;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_r <= 1'b0;
      fifo_rd_en_reg <= 1'b0;
      underflow_count <= 8'h00;
    end else begin
      reg_read_r <= reg_read;
      fifo_rd_en_reg <= rd_rise;   // Normal mode pops after the read
      if (rd_rise && fifo_state == FIFO_EMPTY && underflow_count != 8'hff)
        underflow_count <= underflow_count + 8'd1;
    end
  end

  // Snapshot of the FIFO state when an error first shows up
  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      first_error_seen <= 1'b0;
      first_error_state <= FIFO_EMPTY;
    end else if (!first_error_seen && (errors.overflow || errors.underflow)) begin
      first_error_seen <= 1'b1;
      first_error_state <= fifo_state;
    end
  end

  // Every dropped sample must leave the overflow flag set
  a_drop_flags_overflow: assert property (@(posedge clk_usb) disable iff (reset)
    drop |=> errors.overflow);

  a_rd_en_single: assert property (@(posedge clk_usb) disable iff (reset)
    fifo_rd_en |=> !fifo_rd_en);

endmodule

// ==== rtl/sample_packer.sv ====
`timescale 1ns/100ps
`include "adc_capture_macros.svh"

module sample_packer import adc_capture_pkg::*; (
  input  logic          clk_usb,
  input  logic          reset,
  input  capture_cfg_t  cfg,
  input  adc_sample_t   adc_data,
  input  logic          adc_valid,
  input  logic          credit_return,
  output pack_push_t    push,
  output logic          sample_taken,
  output logic          drop
);

  fifo_count_t credits;
  fifo_count_t need;
  fifo_count_t spend;
  logic        accept;
  logic        pending_valid;
  logic [7:0]  pending_byte;
  logic [7:0]  first_byte;

  assign sample_taken = adc_valid & cfg.enable;
  assign need = cfg.low_res ? 7'd1 : 7'd2;

  // Credits for the whole sample are reserved up front
  assign accept = sample_taken & ~pending_valid & (credits >= need);
  assign drop = sample_taken & ~accept;
  assign spend = accept ? need : 7'd0;

  always_comb begin
    if (!cfg.low_res)
      first_byte = {6'b0, adc_data[9:8]};   // High byte first
    else if (cfg.low_res_lsb)
      first_byte = adc_data[7:0];
    else
      first_byte = adc_data[9:2];
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      credits <= fifo_count_t'(`SAMPLE_FIFO_DEPTH);
      pending_valid <= 1'b0;
      push.valid <= 1'b0;
    end else begin
      credits <= credits - spend + {6'b0, credit_return};
      pending_valid <= accept & ~cfg.low_res;
      push.valid <= accept | pending_valid;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (accept) begin
      push.data <= first_byte;
      pending_byte <= adc_data[7:0];   // Low byte goes out next cycle
    end else if (pending_valid) begin
      push.data <= pending_byte;
    end
  end

  // The FIFO only hands back credits that were spent
  a_no_excess_return: assert property (@(posedge clk_usb) disable iff (reset)
    credit_return |-> credits < fifo_count_t'(`SAMPLE_FIFO_DEPTH));

  // A wrap below zero would land above the depth too
  a_credit_range: assert property (@(posedge clk_usb) disable iff (reset)
    credits <= fifo_count_t'(`SAMPLE_FIFO_DEPTH));

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/100ps
`include "adc_capture_macros.svh"

module sample_fifo import adc_capture_pkg::*; (
  input  logic         clk_usb,
  input  logic         reset,
  input  pack_push_t   push,
  input  logic         fifo_rd_en,
  input  logic         drop,
  input  logic         clear_fifo_errors,
  output logic [7:0]   head_byte,
  output fifo_count_t  fifo_count,
  output fifo_state_t  fifo_state,
  output fifo_error_t  errors,
  output logic         credit_return
);

  logic [7:0]                mem [`SAMPLE_FIFO_DEPTH];
  logic [`FIFO_PTR_BITS-1:0] wr_ptr;
  logic [`FIFO_PTR_BITS-1:0] rd_ptr;
  logic                      empty;
  logic                      full;
  logic                      pop;

  assign empty = (fifo_count == 7'd0);
  assign full = (fifo_count == fifo_count_t'(`SAMPLE_FIFO_DEPTH));
  assign pop = fifo_rd_en & ~empty;

  // Show-ahead, head byte is valid whenever the FIFO holds data
  assign head_byte = empty ? 8'h00 : mem[rd_ptr];

  always_comb begin
    if (empty)
      fifo_state = FIFO_EMPTY;
    else if (full)
      fifo_state = FIFO_FULL;
    else
      fifo_state = FIFO_PARTIAL;
  end

  always_ff @(posedge clk_usb) begin
    if (push.valid)
      mem[wr_ptr] <= push.data;
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fifo_count <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push.valid)
        wr_ptr <= wr_ptr + 1'b1;   // Wraps at the depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push.valid, pop})
        2'b10:   fifo_count <= fifo_count + 7'd1;
        2'b01:   fifo_count <= fifo_count - 7'd1;
        default: fifo_count <= fifo_count;
      endcase
      credit_return <= pop;   // One credit per byte popped
    end
  end

  // Sticky errors, a set in the clearing cycle still wins
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      errors <= '0;
    end else begin
      if (clear_fifo_errors)
        errors <= '0;
      if (drop)
        errors.overflow <= 1'b1;
      if (fifo_rd_en && empty)
        errors.underflow <= 1'b1;
    end
  end

  // Credit accounting in the packer must keep writes off a full FIFO
  a_no_write_when_full: assert property (@(posedge clk_usb) disable iff (reset)
    push.valid |-> !full);

endmodule

// ==== rtl/adc_capture_top.sv ====
`timescale 1ns/100ps

module adc_capture_top import adc_capture_pkg::*; (
  input  logic          clk_usb,
  input  logic          reset,
  input  reg_addr_t     reg_address,
  input  reg_bytecnt_t  reg_bytecnt,
  input  logic [7:0]    reg_datai,
  input  logic          reg_write,
  input  logic          reg_read,
  output logic [7:0]    reg_datao,
  input  adc_sample_t   adc_data,
  input  logic          adc_valid,
  output logic          capture_done
);

  capture_cfg_t cfg;
  pack_push_t   push;
  fifo_error_t  errors;
  fifo_state_t  fifo_state;
  fifo_count_t  fifo_count;
  logic [7:0]   head_byte;
  logic         credit_return;
  logic         sample_taken;
  logic         drop;
  logic         fifo_rd_en;
  logic         clear_fifo_errors;

  // Register file and capture FSM
  adcfifo_regs u_regs (
    .clk_usb, .reset,
    .reg_address, .reg_bytecnt, .reg_datai, .reg_read, .reg_write, .reg_datao,
    .head_byte, .fifo_count, .fifo_state, .errors, .sample_taken, .drop,
    .cfg, .fifo_rd_en, .clear_fifo_errors, .capture_done
  );

  sample_packer u_packer (
    .clk_usb, .reset,
    .cfg, .adc_data, .adc_valid, .credit_return,
    .push, .sample_taken, .drop
  );

  sample_fifo u_fifo (
    .clk_usb, .reset,
    .push, .fifo_rd_en, .drop, .clear_fifo_errors,
    .head_byte, .fifo_count, .fifo_state, .errors, .credit_return
  );

endmodule

// ==== testbench/tb_adc_capture.sv ====
`timescale 1ns/100ps
`include "adc_capture_macros.svh"

module tb_adc_capture import adc_capture_pkg::*; ();

  // Several times the cycles that all captures and bus reads need together
  localparam int MAX_CYCLES = 4000;

  logic         clk_usb = 1'b0;
  logic         reset;
  reg_addr_t    reg_address;
  reg_bytecnt_t reg_bytecnt;
  logic [7:0]   reg_datai;
  logic         reg_write;
  logic         reg_read;
  logic [7:0]   reg_datao;
  adc_sample_t  adc_data;
  logic         adc_valid;
  logic         capture_done;

  logic [31:0]  lfsr_state = 32'hf466_226d;
  logic [7:0]   expected_q[$];     // Bytes the FIFO should hand out, oldest first
  int           cycle_count = 0;

  adc_capture_top dut (
    .clk_usb, .reset,
    .reg_address, .reg_bytecnt, .reg_datai, .reg_write, .reg_read, .reg_datao,
    .adc_data, .adc_valid, .capture_done
  );

  always #4 clk_usb = ~clk_usb;   // 8 ns period

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge clk_usb) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  // Bus is quiet outside a read
  a_datao_idle: assert property (@(posedge clk_usb) disable iff (reset)
    !reg_read |-> reg_datao == 8'h00)
    else begin
      $display("Fail reg_datao is %h while reg_read is low", reg_datao);
      stop_on_failure();
    end

  // Done holds until the host arms the next capture
  a_done_holds: assert property (@(posedge clk_usb) disable iff (reset)
    capture_done && !(reg_write && reg_address == `REG_CAPTURE_CTRL && reg_datai[0])
    |=> capture_done)
    else begin
      $display("Fail capture_done is %h expected %h", capture_done, 1'b1);
      stop_on_failure();
    end

  // Galois form with taps at x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_base(output adc_sample_t base);
    for (int b = 0; b < 10; b++) begin
      base[b] = lfsr_state[0];   // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic reg_wr(input reg_addr_t addr, input reg_bytecnt_t bytecnt,
                        input logic [7:0] data);
    @(posedge clk_usb);
    reg_address <= addr;
    reg_bytecnt <= bytecnt;
    reg_datai <= data;
    reg_write <= 1'b1;
    @(posedge clk_usb);
    reg_write <= 1'b0;
  endtask

  task automatic reg_rd(input reg_addr_t addr, input reg_bytecnt_t bytecnt,
                        output logic [7:0] data, output logic [7:0] late);
    @(posedge clk_usb);
    reg_address <= addr;
    reg_bytecnt <= bytecnt;
    reg_read <= 1'b1;
    @(negedge clk_usb);
    data = reg_datao;            // Sampled in the first cycle
    @(posedge clk_usb);
    @(negedge clk_usb);
    late = reg_datao;            // And again in the second
    @(posedge clk_usb);
    reg_read <= 1'b0;            // One idle cycle before the next read
  endtask

  task automatic check_reg(input string name, input reg_addr_t addr,
                           input reg_bytecnt_t bytecnt, input logic [7:0] expected);
    logic [7:0] got;
    logic [7:0] late;
    reg_rd(addr, bytecnt, got, late);
    assert (got === expected && late === expected) else begin
      $display("Fail reg_datao at %s read %h then %h expected %h",
               name, got, late, expected);
      stop_on_failure();
    end
  endtask

  // Ramp of samples two cycles apart, with reference bytes built from the packing rule
  task automatic feed_ramp(input int n_samples, input int n_stored,
                           input logic low_res, input logic lsb);
    adc_sample_t base;
    adc_sample_t sample;
    random_base(base);
    for (int i = 0; i < n_samples; i++) begin
      sample = base + adc_sample_t'(i);
      if (i < n_stored) begin
        if (!low_res) begin
          expected_q.push_back({6'b0, sample[9:8]});
          expected_q.push_back(sample[7:0]);
        end else if (lsb) begin
          expected_q.push_back(sample[7:0]);
        end else begin
          expected_q.push_back(sample[9:2]);
        end
      end
      @(posedge clk_usb);
      adc_data <= sample;
      adc_valid <= 1'b1;
      @(posedge clk_usb);
      adc_valid <= 1'b0;
    end
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    @(negedge clk_usb);
    while (!capture_done) begin
      waited++;
      if (waited > 8) begin
        $display("capture_done did not rise after the last sample");
        stop_on_failure();
      end
      @(negedge clk_usb);
    end
    repeat (3) @(posedge clk_usb);   // Last bytes leave the packer
  endtask

  task automatic capture_samples(input int n_samples, input int n_stored,
                                 input logic low_res, input logic lsb);
    reg_wr(`REG_ADC_LOW_RES, 7'd0, {6'b0, lsb, low_res});
    reg_wr(`REG_CAPTURE_CTRL, 7'd0, 8'h01);
    feed_ramp(n_samples, n_stored, low_res, lsb);
    wait_done();
  endtask

  task automatic drain_fifo(input int n_bytes, input logic fast);
    logic [7:0] got;
    logic [7:0] late;
    logic [7:0] expected;
    logic [7:0] expected_late;
    for (int i = 0; i < n_bytes; i++) begin
      if (expected_q.size() == 0) begin
        $display("More FIFO reads than expected bytes");
        stop_on_failure();
      end
      expected = expected_q.pop_front();
      // Fast mode pops in the first cycle and shows the next byte in the second
      if (fast && expected_q.size() != 0)
        expected_late = expected_q[0];
      else if (fast)
        expected_late = 8'h00;   // Empty FIFO reads as zero
      else
        expected_late = expected;
      reg_rd(`REG_ADC_READ, 7'd0, got, late);
      assert (got === expected) else begin
        $display("Fail reg_datao at FIFO byte %0d read %h expected %h", i, got, expected);
        stop_on_failure();
      end
      assert (late === expected_late) else begin
        $display("Fail reg_datao at FIFO byte %0d second cycle read %h expected %h",
                 i, late, expected_late);
        stop_on_failure();
      end
    end
    if (expected_q.size() != 0) begin
      $display("Expected bytes are left over after draining the FIFO");
      stop_on_failure();
    end
  endtask

  initial begin
    reset <= 1'b1;
    reg_address <= 8'h00;
    reg_bytecnt <= 7'd0;
    reg_datai <= 8'h00;
    reg_write <= 1'b0;
    reg_read <= 1'b0;
    adc_data <= '0;
    adc_valid <= 1'b0;
    repeat (16) @(posedge clk_usb);
    reset <= 1'b0;

    // Reset values
    assert (!capture_done) else begin
      $display("Fail capture_done is %h expected %h", capture_done, 1'b0);
      stop_on_failure();
    end
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);
    check_reg("fifo_state", `REG_FIFO_STATE, 7'd0, 8'h00);
    check_reg("fifo_first_error", `REG_FIFO_FIRST_ERROR, 7'd0, 8'h00);
    check_reg("capture_len byte 0", `REG_CAPTURE_LEN, 7'd0, 8'd24);
    check_reg("capture_len byte 1", `REG_CAPTURE_LEN, 7'd1, 8'h00);
    check_reg("adc_low_res", `REG_ADC_LOW_RES, 7'd0, 8'h00);
    check_reg("underflow_count", `REG_UNDERFLOW_COUNT, 7'd0, 8'h00);
    check_reg("no_underflow_error", `REG_NO_UNDERFLOW_ERROR, 7'd0, 8'h00);
    check_reg("capture_ctrl", `REG_CAPTURE_CTRL, 7'd0, 8'h00);
    check_reg("fast_fifo_read", `REG_FAST_FIFO_READ, 7'd0, 8'h00);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'h00);

    // Full resolution with normal reads
    capture_samples(24, 24, 1'b0, 1'b0);
    check_reg("capture_ctrl", `REG_CAPTURE_CTRL, 7'd0, 8'h02);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'd48);
    drain_fifo(48, 1'b0);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'h00);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);

    // Low resolution with top bits then bottom bits
    capture_samples(24, 24, 1'b1, 1'b0);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'd24);
    drain_fifo(24, 1'b0);
    capture_samples(24, 24, 1'b1, 1'b1);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'd24);
    drain_fifo(24, 1'b0);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);

    // 40 samples into 64 bytes leave the last 8 without credit
    reg_wr(`REG_CAPTURE_LEN, 7'd0, 8'd40);
    reg_wr(`REG_CAPTURE_LEN, 7'd1, 8'h00);
    capture_samples(40, 32, 1'b0, 1'b0);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h01);
    check_reg("fifo_first_error", `REG_FIFO_FIRST_ERROR, 7'd0, {6'b0, FIFO_FULL});
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'd64);
    drain_fifo(64, 1'b0);
    reg_wr(`REG_FIFO_STAT, 7'd0, 8'h01);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);
    check_reg("fifo_first_error", `REG_FIFO_FIRST_ERROR, 7'd0, 8'h00);

    // Underflow counting and masking
    repeat (3) check_reg("empty adc_read", `REG_ADC_READ, 7'd0, 8'h00);
    check_reg("underflow_count", `REG_UNDERFLOW_COUNT, 7'd0, 8'd3);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h06);
    reg_wr(`REG_NO_UNDERFLOW_ERROR, 7'd0, 8'h01);
    check_reg("no_underflow_error", `REG_NO_UNDERFLOW_ERROR, 7'd0, 8'h01);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);
    check_reg("empty adc_read", `REG_ADC_READ, 7'd0, 8'h00);
    check_reg("underflow_count", `REG_UNDERFLOW_COUNT, 7'd0, 8'd4);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);
    reg_wr(`REG_NO_UNDERFLOW_ERROR, 7'd0, 8'h00);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h06);
    reg_wr(`REG_FIFO_STAT, 7'd0, 8'h01);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);

    // Fast read mode until any other write drops it
    reg_wr(`REG_CAPTURE_LEN, 7'd0, 8'd16);
    capture_samples(16, 16, 1'b0, 1'b0);
    reg_wr(`REG_FAST_FIFO_READ, 7'd0, 8'h01);
    check_reg("fast_fifo_read", `REG_FAST_FIFO_READ, 7'd0, 8'h01);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'd32);
    drain_fifo(32, 1'b1);
    check_reg("fifo_count", `REG_FIFO_COUNT, 7'd0, 8'h00);
    check_reg("fifo_stat", `REG_FIFO_STAT, 7'd0, 8'h04);
    reg_wr(`REG_CAPTURE_LEN, 7'd0, 8'd24);
    check_reg("fast_fifo_read", `REG_FAST_FIFO_READ, 7'd0, 8'h00);
    check_reg("capture_len byte 0", `REG_CAPTURE_LEN, 7'd0, 8'd24);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/adc_capture_pkg.sv
rtl/adcfifo_regs.sv
rtl/sample_packer.sv
rtl/sample_fifo.sv
rtl/adc_capture_top.sv
testbench/tb_adc_capture.sv

// ==== Makefile ====
TOP = tb_adc_capture

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
